// ==== audio_panel.f ====
verilog/ac97_pkg.sv
verilog/panel_pkg.sv
verilog/debounce.sv
verilog/volume_control.sv
verilog/ac97_command_sequencer.sv
verilog/ac97_frame_link.sv
verilog/ac97_bridge.sv
verilog/audio_panel.sv
test/audio_panel_checker.sv
test/audio_panel_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := audio_panel_tb
FILELIST   := audio_panel.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT  := TEST PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/audio_panel_tb.sv ====
`timescale 1ns/1ps

module audio_panel_tb;

  localparam int debounce_cycles    = 20;
  localparam int codec_reset_cycles = 30;
  localparam int frame_ns           = 512 * 9;   // one frame at the bit clock
  localparam int press_cycles       = 30;        // past the debounce window
  localparam int glitch_cycles      = 5;

  localparam logic [1:0] act_up   = 2'd0;
  localparam logic [1:0] act_down = 2'd1;
  localparam logic [1:0] act_play = 2'd2;
  localparam logic [1:0] act_cap  = 2'd3;

  logic        clock_27mhz    = 1'b0;
  logic        ac97_bit_clock = 1'b0;
  logic        reset;
  logic        button_up;
  logic        button_down;
  logic [11:0] audio_out_data;
  logic [11:0] audio_in_data;
  logic        ready;
  logic [4:0]  volume;
  logic        audio_reset_b;
  logic        ac97_sdata_out;
  logic        ac97_synch;
  logic        ac97_sdata_in  = 1'b0;

  logic [1:0]  row_kind;
  logic [19:0] row_expect;
  logic        row_check;
  int          row_index;
  int          frames;
  int          row_passes;
  int          fails;
  int          frame_fails;

  // stimulus table of action, value and expected
  logic [1:0]  tab_act [$];
  logic [19:0] tab_val [$];
  logic [19:0] tab_exp [$];
  logic        table_ready = 1'b0;
  int          seed;
  int          f0;

  // codec model state
  logic [19:0] cap_word      = 20'h0;
  logic [19:0] cap_frame     = 20'h0;
  logic        codec_synch_q = 1'b0;
  int          codec_pos     = 1000;

  always #2 clock_27mhz = ~clock_27mhz;        // 4 ns
  always #4.5 ac97_bit_clock = ~ac97_bit_clock;  // 9 ns

  audio_panel #(
    .debounce_cycles    (debounce_cycles),
    .codec_reset_cycles (codec_reset_cycles)
  ) dut0 (
    .clock_27mhz    (clock_27mhz),
    .reset          (reset),
    .button_up      (button_up),
    .button_down    (button_down),
    .audio_out_data (audio_out_data),
    .audio_in_data  (audio_in_data),
    .ready          (ready),
    .volume         (volume),
    .audio_reset_b  (audio_reset_b),
    .ac97_sdata_out (ac97_sdata_out),
    .ac97_synch     (ac97_synch),
    .ac97_sdata_in  (ac97_sdata_in),
    .ac97_bit_clock (ac97_bit_clock)
  );

  audio_panel_checker #(.codec_reset_cycles(codec_reset_cycles)) check0 (
    .clock_27mhz    (clock_27mhz),
    .reset          (reset),
    .ac97_bit_clock (ac97_bit_clock),
    .ready          (ready),
    .audio_reset_b  (audio_reset_b),
    .ac97_synch     (ac97_synch),
    .ac97_sdata_out (ac97_sdata_out),
    .volume         (volume),
    .audio_out_data (audio_out_data),
    .audio_in_data  (audio_in_data),
    .row_check      (row_check),
    .row_kind       (row_kind),
    .row_expect     (row_expect),
    .row_index      (row_index),
    .frames         (frames),
    .row_passes     (row_passes),
    .fails          (fails),
    .frame_fails    (frame_fails)
  );

  // codec drives slot 3 for the next falling edge, counting from synch
  always @(negedge ac97_bit_clock) begin
    if (ac97_synch === 1'b1 && codec_synch_q !== 1'b1) begin
      codec_pos = -1;        // synch rose at count 511
      cap_frame = cap_word;
    end
    codec_synch_q = ac97_synch;
    codec_pos = codec_pos + 1;
    if (codec_pos >= 56 && codec_pos <= 75)
      ac97_sdata_in <= cap_frame[75 - codec_pos];
    else
      ac97_sdata_in <= 1'b0;
  end

  task automatic add_row(input logic [1:0] act, input logic [19:0] val,
                         input logic [19:0] exp);
    tab_act.push_back(act);
    tab_val.push_back(val);
    tab_exp.push_back(exp);
  endtask

  task automatic add_sample_rows();
    logic [19:0] r;
    r = 20'($random(seed));
    add_row(act_play, {8'h00, r[11:0]}, {8'h00, r[11:0]});
    r = 20'($random(seed));
    add_row(act_cap, r, {8'h00, r[19:8]});   // top 12 bits come back
  endtask

  task automatic build_table();
    int vol;
    vol = 8;
    add_row(act_up, 20'(glitch_cycles), 20'(vol));   // too short to count
    add_sample_rows();
    for (int i = 0; i < 26; i++) begin
      vol = (vol == 31) ? 31 : vol + 1;   // holds at the top
      add_row(act_up, 20'(press_cycles), 20'(vol));
      if (i % 9 == 4)
        add_sample_rows();
    end
    add_row(act_down, 20'(glitch_cycles), 20'(vol));
    for (int i = 0; i < 34; i++) begin
      vol = (vol == 0) ? 0 : vol - 1;
      add_row(act_down, 20'(press_cycles), 20'(vol));
      if (i % 11 == 6)
        add_sample_rows();
    end
  endtask

  task automatic apply_row(input int i);
    int start;
    @(negedge clock_27mhz);
    case (tab_act[i])
      act_up, act_down: begin
        if (tab_act[i] == act_up)
          button_up = 1'b0;    // buttons are low when pressed
        else
          button_down = 1'b0;
        repeat (tab_val[i]) @(negedge clock_27mhz);
        button_up   = 1'b1;
        button_down = 1'b1;
        repeat (press_cycles) @(negedge clock_27mhz);
      end
      default: begin
        if (tab_act[i] == act_play)
          audio_out_data = tab_val[i][11:0];
        else
          cap_word = tab_val[i];
        start = frames;
        wait (frames >= start + 3);   // ready, latch, then a full frame out
        @(negedge clock_27mhz);
      end
    endcase
    row_index  = i;
    row_kind   = tab_act[i];
    row_expect = tab_exp[i];
    row_check  = 1'b1;
    @(negedge clock_27mhz);
    row_check = 1'b0;
  endtask

  initial begin
    seed           = 32'h6206467e;
    reset          = 1'b1;
    button_up      = 1'b1;
    button_down    = 1'b1;
    audio_out_data = 12'h000;
    row_check      = 1'b0;
    row_kind       = 2'd0;
    row_expect     = 20'h0;
    row_index      = 0;
    build_table();
    table_ready = 1'b1;
    repeat (4) @(posedge clock_27mhz);
    @(negedge clock_27mhz);
    reset = 1'b0;

    for (int i = 0; i < tab_act.size(); i++)
      apply_row(i);

    f0 = frames;
    wait (frames >= f0 + 2);   // let the frame checks run on
    $display("tests passed %0d, failed %0d, frame errors %0d",
             row_passes, tab_act.size() - row_passes, frame_fails);
    if (fails == 0 && frame_fails == 0 && row_passes == tab_act.size())
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int limit;
    wait (table_ready);
    limit = (8 + codec_reset_cycles + 2 * debounce_cycles) * 4 + 2 * frame_ns +
            tab_act.size() * (4 * frame_ns + 4 * (2 * press_cycles + 4));
    #(limit);
    $display("timeout: test table still running after %0d ns", limit);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== test/audio_panel_checker.sv ====
`timescale 1ns/1ps

module audio_panel_checker #(
  parameter int codec_reset_cycles = 1023
) (
  input  logic        clock_27mhz,
  input  logic        reset,
  input  logic        ac97_bit_clock,
  input  logic        ready,
  input  logic        audio_reset_b,
  input  logic        ac97_synch,
  input  logic        ac97_sdata_out,
  input  logic [4:0]  volume,
  input  logic [11:0] audio_out_data,
  input  logic [11:0] audio_in_data,
  input  logic        row_check,    // one cycle, compare the current row
  input  logic [1:0]  row_kind,
  input  logic [19:0] row_expect,
  input  int          row_index,
  output int          frames,       // frames decoded so far
  output int          row_passes,
  output int          fails,
  output int          frame_fails
);

  logic [3:0]  step = 4'h0;       // expected table position
  logic [11:0] held;              // playback sample the DUT should hold
  logic [11:0] last_left;         // sample from slot 3 of the last frame
  logic [4:0]  vol_q1;
  logic [4:0]  vol_q2;
  int          ready_total = 0;
  int          cyc = 0;           // cycles since reset fell
  logic        released = 1'b0;
  int          start;

  logic [95:0] bits;              // slots 0 to 4, first bit at the top
  logic        synch_q = 1'b0;
  logic        started = 1'b0;
  int          pos = 1000;        // bit position in the frame
  int          period = 0;
  int          high_len = 0;
  int          ready_mark = 0;
  logic [3:0]  f_step;
  logic [11:0] f_held;
  logic [4:0]  f_vol0;
  logic [4:0]  f_vol1;
  logic [4:0]  f_vol2;

  initial begin
    frames      = 0;
    row_passes  = 0;
    fails       = 0;
    frame_fails = 0;
    last_left   = '0;
  end

  task automatic differ(input string name, input logic [31:0] got,
                        input logic [31:0] exp, inout int count);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      count++;
    end
  endtask

  // register writes the codec should see, by step
  function automatic logic [23:0] table_cmd(input logic [3:0] s, input logic [4:0] v);
    logic [4:0] att;
    att = 5'd31 - v;   // attenuation, not gain
    case (s)
      4'h3:    table_cmd = {8'h04, 3'b000, att, 3'b000, att};
      4'h5:    table_cmd = 24'h180808;
      4'h6:    table_cmd = 24'h1A0000;   // mic on both sides
      4'h7:    table_cmd = 24'h1C0F0F;
      4'h9:    table_cmd = 24'h0E8048;
      4'hA:    table_cmd = 24'h0A0000;
      4'hB:    table_cmd = 24'h208000;
      default: table_cmd = 24'h800000;   // id read
    endcase
  endfunction

  function automatic logic [39:0] slots12(input logic [23:0] c);
    slots12 = {c[23:16], 12'h000, c[15:0], 4'h0};   // left-justified fields
  endfunction

  task automatic check_frame();
    logic [23:0] want;
    // volume may have moved a cycle or two before the latch
    want = table_cmd(f_step, f_vol0);
    if (bits[79:40] !== slots12(want))
      want = table_cmd(f_step, f_vol1);
    if (bits[79:40] !== slots12(want))
      want = table_cmd(f_step, f_vol2);
    differ("slot0 tags", 32'(bits[95:80]), 32'h0000F800, frame_fails);
    differ("slot1 address", 32'(bits[79:60]), 32'(slots12(want) >> 20), frame_fails);
    differ("slot2 data", 32'(bits[59:40]), 32'(slots12(want) & 40'hFFFFF), frame_fails);
    differ("slot3 left", 32'(bits[39:20]), 32'({f_held, 8'h00}), frame_fails);
    differ("slot4 right", 32'(bits[19:0]), 32'({f_held, 8'h00}), frame_fails);
    last_left = bits[39:28];
    frames++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // clock_27mhz side with reference model, reset checks and row results
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clock_27mhz) begin
    vol_q2 <= vol_q1;
    vol_q1 <= volume;
    if (reset) begin
      step        <= 4'h0;
      ready_total <= 0;
      cyc         <= 0;
      released    <= 1'b0;
    end else begin
      cyc <= cyc + 1;
      if (ready) begin
        step        <= step + 1'b1;
        held        <= audio_out_data;   // captured on the pulse
        ready_total <= ready_total + 1;
      end
      if (cyc == 0) begin   // first cycle out of reset
        differ("volume", 32'(volume), 32'd8, fails);
        differ("audio_reset_b", 32'(audio_reset_b), 32'd0, fails);
        differ("ready", 32'(ready), 32'd0, fails);
      end
      if (cyc == 4)
        differ("ac97_synch", 32'(ac97_synch), 32'd0, fails);
      if (!released && audio_reset_b === 1'b1) begin
        differ("audio_reset_b delay", 32'(cyc), 32'(codec_reset_cycles + 1), fails);
        released <= 1'b1;
      end else if (released && audio_reset_b !== 1'b1) begin
        $display("audio_reset_b fell again after the codec was released");
        fails++;
      end
      if (row_check) begin
        start = fails;
        case (row_kind)
          2'd2:    differ("playback slot3", 32'(last_left), 32'(row_expect), fails);
          2'd3:    differ("audio_in_data", 32'(audio_in_data), 32'(row_expect), fails);
          default: differ("volume", 32'(volume), 32'(row_expect), fails);
        endcase
        if (fails == start) begin
          row_passes++;
          $display("test %0d kind %0d ok", row_index, row_kind);
        end else begin
          $display("test %0d kind %0d failed", row_index, row_kind);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // frame decode on the bit clock falling edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge ac97_bit_clock) begin
    period = period + 1;
    if (ac97_synch === 1'b1)
      high_len = high_len + 1;
    if (ac97_synch === 1'b1 && synch_q !== 1'b1) begin   // synch rose at count 511
      if (started) begin
        if (period != 512) begin
          $display("synch rising edges %0d bit clocks apart, not 512", period);
          frame_fails++;
        end
        if (ready_total - ready_mark != 1) begin
          $display("%0d ready pulses in one frame", ready_total - ready_mark);
          frame_fails++;
        end
      end
      started    = 1'b1;
      period     = 0;
      pos        = -1;
      ready_mark = ready_total;
      f_step     = step;     // what the payload latched just now
      f_held     = held;
      f_vol0     = volume;
      f_vol1     = vol_q1;
      f_vol2     = vol_q2;
    end else begin
      pos = pos + 1;
    end
    if (ac97_synch !== 1'b1 && synch_q === 1'b1) begin
      if (high_len != 16) begin
        $display("synch pulse lasted %0d bit clocks", high_len);
        frame_fails++;
      end
      high_len = 0;
    end
    synch_q = ac97_synch;
    if (pos >= 0 && pos <= 95)
      bits[95 - pos] = ac97_sdata_out;
    if (pos == 95)
      check_frame();
  end

endmodule

// ==== verilog/audio_panel.sv ====
`timescale 1ns/1ps

module audio_panel #(
  parameter int debounce_cycles    = 270000,   // 10 ms at 27 MHz
  parameter int codec_reset_cycles = 1023
) (
  input  logic                            clock_27mhz,
  input  logic                            reset,
  input  logic                            button_up,       // low when pressed
  input  logic                            button_down,     // low when pressed
  input  logic [ac97_pkg::audio_bits-1:0] audio_out_data,
  output logic [ac97_pkg::audio_bits-1:0] audio_in_data,
  output logic                            ready,
  output logic [panel_pkg::vol_bits-1:0]  volume,
  output logic                            audio_reset_b,
  output logic                            ac97_sdata_out,
  output logic                            ac97_synch,
  input  logic                            ac97_sdata_in,
  input  logic                            ac97_bit_clock
);

  logic up_clean;
  logic down_clean;

  ////////////////////////////////////////////////////////////////////////////
  // front panel
  ////////////////////////////////////////////////////////////////////////////

  debounce #(.debounce_cycles(debounce_cycles)) bounce_up (
    .clock_27mhz (clock_27mhz),
    .reset       (reset),
    .noisy       (~button_up),   // high while pressed
    .clean       (up_clean)
  );

  debounce #(.debounce_cycles(debounce_cycles)) bounce_down (
    .clock_27mhz (clock_27mhz),
    .reset       (reset),
    .noisy       (~button_down),
    .clean       (down_clean)
  );

  volume_control vol0 (
    .clock_27mhz (clock_27mhz),
    .reset       (reset),
    .up          (up_clean),
    .down        (down_clean),
    .volume      (volume)
  );

  // codec side
  ac97_bridge #(.codec_reset_cycles(codec_reset_cycles)) bridge0 (
    .clock_27mhz    (clock_27mhz),
    .reset          (reset),
    .volume         (volume),
    .audio_out_data (audio_out_data),
    .audio_in_data  (audio_in_data),
    .ready          (ready),
    .audio_reset_b  (audio_reset_b),
    .ac97_sdata_out (ac97_sdata_out),
    .ac97_sdata_in  (ac97_sdata_in),
    .ac97_synch     (ac97_synch),
    .ac97_bit_clock (ac97_bit_clock)
  );

endmodule

// ==== verilog/ac97_bridge.sv ====
`timescale 1ns/1ps

module ac97_bridge #(
  parameter int codec_reset_cycles = 1023
) (
  input  logic                            clock_27mhz,
  input  logic                            reset,
  input  logic [panel_pkg::vol_bits-1:0]  volume,
  input  logic [ac97_pkg::audio_bits-1:0] audio_out_data,   // playback sample
  output logic [ac97_pkg::audio_bits-1:0] audio_in_data,    // capture sample
  output logic                            ready,
  output logic                            audio_reset_b,    // codec reset, low active
  output logic                            ac97_sdata_out,
  input  logic                            ac97_sdata_in,
  output logic                            ac97_synch,
  input  logic                            ac97_bit_clock
);

  localparam int rc_bits  = $clog2(codec_reset_cycles + 1);
  localparam int pad_bits = ac97_pkg::sample_bits - ac97_pkg::audio_bits;

  logic [rc_bits-1:0]               reset_count;
  logic [2:0]                       ready_sync;      // frame_ready into clock_27mhz
  logic [1:0]                       bit_reset_sync;  // reset into bit clock
  logic                             bit_reset;
  logic                             frame_ready;
  logic [ac97_pkg::audio_bits-1:0]  out_data;
  logic [ac97_pkg::sample_bits-1:0] out_padded;
  logic [ac97_pkg::sample_bits-1:0] left_in_data;
  ac97_pkg::ac97_cmd_t              command;
  logic                             command_valid;

  // give the codec time before releasing its reset
  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      reset_count   <= '0;
      audio_reset_b <= 1'b0;
    end else if (reset_count == rc_bits'(codec_reset_cycles)) begin
      audio_reset_b <= 1'b1;
    end else begin
      reset_count <= reset_count + 1'b1;
    end
  end

  always_ff @(posedge clock_27mhz) begin
    if (reset)
      ready_sync <= 3'b000;
    else
      ready_sync <= {ready_sync[1:0], frame_ready};
  end
  assign ready = ready_sync[1] & ~ready_sync[2];   // rising edge, one cycle

  always_ff @(posedge ac97_bit_clock) begin
    bit_reset_sync <= {bit_reset_sync[0], reset};
  end
  assign bit_reset = bit_reset_sync[1];

  // hold playback sample for a whole frame
  always_ff @(posedge clock_27mhz) begin
    if (ready)
      out_data <= audio_out_data;
  end
  assign out_padded    = {out_data, {pad_bits{1'b0}}};   // mono, low bits zero
  assign audio_in_data = left_in_data[ac97_pkg::sample_bits-1 -: ac97_pkg::audio_bits];

  ac97_frame_link link0 (
    .ac97_bit_clock (ac97_bit_clock),
    .bit_reset      (bit_reset),
    .frame_ready    (frame_ready),
    .command        (command),
    .command_valid  (command_valid),
    .left_data      (out_padded),
    .right_data     (out_padded),      // same sample both sides
    .left_in_data   (left_in_data),
    .ac97_sdata_in  (ac97_sdata_in),
    .ac97_sdata_out (ac97_sdata_out),
    .ac97_synch     (ac97_synch)
  );

  ac97_command_sequencer seq0 (
    .clock_27mhz   (clock_27mhz),
    .reset         (reset),
    .ready         (ready),
    .volume        (volume),
    .command       (command),
    .command_valid (command_valid)
  );

  // frame ready crossing yields single pulses only
  ready_pulse: assert property (
    @(posedge clock_27mhz) disable iff (reset)
    ready |=> !ready
  );

endmodule

// ==== verilog/ac97_frame_link.sv ====
`timescale 1ns/1ps

module ac97_frame_link (
  input  logic                             ac97_bit_clock,
  input  logic                             bit_reset,       // reset, bit clock domain
  output logic                             frame_ready,
  input  ac97_pkg::ac97_cmd_t              command,
  input  logic                             command_valid,
  input  logic [ac97_pkg::sample_bits-1:0] left_data,
  input  logic [ac97_pkg::sample_bits-1:0] right_data,
  output logic [ac97_pkg::sample_bits-1:0] left_in_data,
  input  logic                             ac97_sdata_in,
  output logic                             ac97_sdata_out,
  output logic                             ac97_synch
);

  localparam int cnt_bits     = $clog2(ac97_pkg::frame_bits);
  localparam int payload_bits = 4 * ac97_pkg::sample_bits;   // slots 1 to 4
  localparam int pad_addr     = ac97_pkg::sample_bits - 8;
  localparam int pad_data     = ac97_pkg::sample_bits - 16;

  localparam logic [cnt_bits-1:0] last_count = cnt_bits'(ac97_pkg::frame_bits - 1);

  logic [cnt_bits-1:0]     bit_count;
  logic [payload_bits-1:0] payload;   // outgoing slots, msb leaves first
  logic                    l_cmd_v;   // command valid for this frame

  ////////////////////////////////////////////////////////////////////////////
  // serializer, rising edge
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge ac97_bit_clock) begin
    if (bit_reset) begin
      bit_count      <= '0;
      ac97_synch     <= 1'b0;
      ac97_sdata_out <= 1'b0;
      frame_ready    <= 1'b0;
      l_cmd_v        <= 1'b0;
    end else begin
      bit_count <= bit_count + 1'b1;   // wraps at frame_bits

      // synch brackets slot 0
      if (bit_count == last_count)
        ac97_synch <= 1'b1;
      else if (bit_count == cnt_bits'(ac97_pkg::slot0_end))
        ac97_synch <= 1'b0;

      // ready level for the user side
      if (bit_count == cnt_bits'(ac97_pkg::ready_rise))
        frame_ready <= 1'b1;
      else if (bit_count == cnt_bits'(ac97_pkg::ready_fall))
        frame_ready <= 1'b0;

      if (bit_count == last_count)
        l_cmd_v <= command_valid;   // first frame after reset goes out empty

      if (bit_count <= cnt_bits'(ac97_pkg::slot0_end)) begin
        case (bit_count[3:0])   // tag bits
          4'h0: ac97_sdata_out <= 1'b1;      // frame valid
          4'h1: ac97_sdata_out <= l_cmd_v;   // address valid
          4'h2: ac97_sdata_out <= l_cmd_v;   // data valid
          4'h3: ac97_sdata_out <= 1'b1;      // left always valid
          4'h4: ac97_sdata_out <= 1'b1;      // right always valid
          default: ac97_sdata_out <= 1'b0;
        endcase
      end else if (bit_count <= cnt_bits'(ac97_pkg::slot4_end)) begin
        ac97_sdata_out <= payload[payload_bits-1];
      end else begin
        ac97_sdata_out <= 1'b0;   // idle slots
      end
    end
  end

  // latch user data at frame end, shift through slots 1 to 4
  always_ff @(posedge ac97_bit_clock) begin
    if (bit_count == last_count) begin
      payload <= command_valid ?
        {command.field.addr, {pad_addr{1'b0}},
         command.field.data, {pad_data{1'b0}},
         left_data, right_data} :
        {{(2 * ac97_pkg::sample_bits){1'b0}}, left_data, right_data};
    end else if (bit_count > cnt_bits'(ac97_pkg::slot0_end) &&
                 bit_count <= cnt_bits'(ac97_pkg::slot4_end)) begin
      payload <= {payload[payload_bits-2:0], 1'b0};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // deserializer, falling edge, left channel only
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(negedge ac97_bit_clock) begin
    if (bit_reset)
      left_in_data <= '0;
    else if (bit_count >= cnt_bits'(ac97_pkg::slot2_end + 2) &&
             bit_count <= cnt_bits'(ac97_pkg::slot3_end + 1))
      left_in_data <= {left_in_data[ac97_pkg::sample_bits-2:0], ac97_sdata_in};
  end

  // synch only around slot 0
  synch_window: assert property (
    @(posedge ac97_bit_clock) disable iff (bit_reset)
    ac97_synch |-> (bit_count <= cnt_bits'(ac97_pkg::slot0_end) || bit_count == last_count)
  );

endmodule

// ==== verilog/ac97_command_sequencer.sv ====
`timescale 1ns/1ps

module ac97_command_sequencer (
  input  logic                           clock_27mhz,
  input  logic                           reset,
  input  logic                           ready,           // one pulse per frame
  input  logic [panel_pkg::vol_bits-1:0] volume,
  output ac97_pkg::ac97_cmd_t            command,
  output logic                           command_valid
);

  logic [3:0]                     step;          // table position
  logic [panel_pkg::vol_bits-1:0] attenuation;   // codec wants attenuation, not gain
  ac97_pkg::ac97_cmd_t            next_cmd;

  assign attenuation = panel_pkg::vol_max - volume;

  ////////////////////////////////////////////////////////////////////////////
  // command table
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (step)
      4'h3: begin   // headphone, same attenuation on both sides
        next_cmd.raw = {ac97_pkg::reg_headphone_vol,
                        {(8 - panel_pkg::vol_bits){1'b0}}, attenuation,
                        {(8 - panel_pkg::vol_bits){1'b0}}, attenuation};
      end
      4'h5: next_cmd.raw = {ac97_pkg::reg_pcm_vol, 16'h0808};   // pcm out level
      4'h6: begin   // record from mic, both channels
        next_cmd.raw = {ac97_pkg::reg_rec_select,
                        5'b00000, ac97_pkg::rec_source_mic,
                        5'b00000, ac97_pkg::rec_source_mic};
      end
      4'h7: next_cmd.raw = {ac97_pkg::reg_rec_gain, 16'h0F0F};  // record gain max
      4'h9: next_cmd.raw = {ac97_pkg::reg_mic_gain, 16'h8048};  // +20 dB boost
      4'hA: next_cmd.raw = {ac97_pkg::reg_beep_vol, 16'h0000};
      4'hB: next_cmd.raw = {ac97_pkg::reg_general, 16'h8000};   // pcm out bypasses mix1
      default: next_cmd.raw = {ac97_pkg::reg_read_id, 16'h0000};  // harmless read
    endcase
  end

  // step walks the table, one entry per frame
  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      step          <= 4'h0;
      command_valid <= 1'b0;
    end else begin
      if (ready)
        step <= step + 1'b1;   // wraps after 15
      if (step == 4'h0)
        command_valid <= 1'b1; // stays set from here on
    end
  end

  // reloaded every cycle from the table
  always_ff @(posedge clock_27mhz) begin
    command <= next_cmd;
  end

endmodule

// ==== verilog/volume_control.sv ====
`timescale 1ns/1ps

module volume_control (
  input  logic                          clock_27mhz,
  input  logic                          reset,
  input  logic                          up,      // debounced, high while pressed
  input  logic                          down,    // debounced, high while pressed
  output logic [panel_pkg::vol_bits-1:0] volume
);

  logic up_last;     // levels from the previous cycle
  logic down_last;
  logic up_edge;
  logic down_edge;

  // press = rising edge of the clean level
  assign up_edge   = up & ~up_last;
  assign down_edge = down & ~down_last;

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      volume    <= panel_pkg::vol_reset;
      up_last   <= 1'b0;
      down_last <= 1'b0;
    end else begin
      up_last   <= up;
      down_last <= down;
      if (up_edge && volume != panel_pkg::vol_max)
        volume <= volume + 1'b1;   // step up, saturate at top
      // down comes second so it overrides a same-cycle up
      if (down_edge && volume != panel_pkg::vol_min)
        volume <= volume - 1'b1;   // step down, saturate at bottom
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // volume moves by one step at most
  single_step: assert property (
    @(posedge clock_27mhz) disable iff (reset)
    !$past(reset) |->
      (volume == $past(volume)) ||
      (int'(volume) == int'($past(volume)) + 1) ||
      (int'(volume) == int'($past(volume)) - 1)
  );

endmodule

// ==== verilog/debounce.sv ====
`timescale 1ns/1ps

module debounce #(
  parameter int debounce_cycles = 270000   // 10 ms at 27 MHz
) (
  input  logic clock_27mhz,
  input  logic reset,
  input  logic noisy,   // raw button level
  output logic clean    // filtered level
);

  localparam int count_bits = $clog2(debounce_cycles + 1);

  logic [count_bits-1:0] count;   // cycles since last change
  logic                  last;    // most recent raw value

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      count <= '0;
      last  <= noisy;
      clean <= noisy;   // start out agreeing with the pin
    end else if (noisy != last) begin
      // input moved, restart the wait
      last  <= noisy;
      count <= '0;
    end else if (count == count_bits'(debounce_cycles)) begin
      clean <= last;    // held long enough
    end else begin
      count <= count + 1'b1;
    end
  end

  // counter parks at the limit and never runs past it
  count_bounded: assert property (
    @(posedge clock_27mhz) disable iff (reset)
    count <= count_bits'(debounce_cycles)
  );

endmodule

// ==== verilog/panel_pkg.sv ====
package panel_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // front panel volume setting
  ////////////////////////////////////////////////////////////////////////////

  // codec headphone attenuation field is 5 bits
  localparam int vol_bits = 5;

  localparam logic [vol_bits-1:0] vol_max = 5'd31;  // loudest, zero attenuation
  localparam logic [vol_bits-1:0] vol_min = 5'd0;   // quietest

  // volume right after reset
  localparam logic [vol_bits-1:0] vol_reset = 5'd8;

  // buttons step by one per press
  // and hold at either limit

endpackage

// ==== verilog/ac97_pkg.sv ====
package ac97_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // frame layout, counted in bit clocks
  ////////////////////////////////////////////////////////////////////////////

  localparam int frame_bits = 512;   // bit counter period

  // last bit count of each slot
  localparam int slot0_end = 15;     // tags
  localparam int slot1_end = 35;     // command address
  localparam int slot2_end = 55;     // command data
  localparam int slot3_end = 75;     // left pcm
  localparam int slot4_end = 95;     // right pcm

  localparam int ready_rise = 256;   // frame ready level sets here
  localparam int ready_fall = 2;     // and clears here

  localparam int sample_bits = 20;   // slot width
  localparam int audio_bits  = 12;   // user sample width

  ////////////////////////////////////////////////////////////////////////////
  // codec register map
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [7:0] reg_read_id       = 8'h80;  // read of vendor id
  localparam logic [7:0] reg_headphone_vol = 8'h04;
  localparam logic [7:0] reg_pcm_vol       = 8'h18;
  localparam logic [7:0] reg_rec_select    = 8'h1A;
  localparam logic [7:0] reg_rec_gain      = 8'h1C;
  localparam logic [7:0] reg_mic_gain      = 8'h0E;
  localparam logic [7:0] reg_beep_vol      = 8'h0A;
  localparam logic [7:0] reg_general       = 8'h20;

  localparam logic [2:0] rec_source_mic = 3'd0;  // record select code for mic

  // one codec command, raw word or address over data
  typedef union packed {
    logic [23:0] raw;
    struct packed {
      logic [7:0]  addr;   // register address
      logic [15:0] data;   // register write data
    } field;
  } ac97_cmd_t;

endpackage
